// ==== verilog/spmv_params.svh ====
// sparse-row dot product widths
`ifndef SPMV_PARAMS_SVH
`define SPMV_PARAMS_SVH

// lanes carried by one input beat
`define SPMV_LANES 4

// signed matrix or vector element
`define SPMV_ELEM_W 8

// one lane product, 8 x 8 signed
`define SPMV_PROD_W 16

// in-beat segment sum, up to four products
`define SPMV_SEG_W 18

// row sum, wraps modulo 2^24
`define SPMV_ACC_W 24

// row or segment count, 0 to 4
`define SPMV_CNT_W 3

`endif

// ==== verilog/spmv_pkg.sv ====
// sparse-row dot product types
`default_nettype none

`include "spmv_params.svh"

package spmv_pkg;

    // lane arrays, lane 0 sits at index 0
    typedef logic [`SPMV_LANES-1:0][`SPMV_ELEM_W-1:0] elem_lanes_t;
    typedef logic [`SPMV_LANES-1:0][`SPMV_PROD_W-1:0] prod_lanes_t;
    typedef logic [`SPMV_LANES-1:0][`SPMV_SEG_W-1:0] seg_lanes_t;
    typedef logic [`SPMV_LANES-1:0][`SPMV_ACC_W-1:0] acc_lanes_t;

    // boundary mask, bit i closes a row after product i
    typedef logic [`SPMV_LANES-2:0] bounds_t;

    typedef logic [`SPMV_CNT_W-1:0] count_t;

    // input beat
    typedef struct packed {
        elem_lanes_t mat;
        elem_lanes_t vec;
        bounds_t     bounds;
        logic        cont;
    } spmv_beat_t;

    // after the multiply stage
    typedef struct packed {
        prod_lanes_t prod;
        bounds_t     bounds;
        logic        cont;
    } prod_beat_t;

    // segment sums packed from lane 0, unused lanes zero
    typedef struct packed {
        seg_lanes_t sums;
        count_t     seg_count;
        logic       cont;
    } seg_beat_t;

    // completed rows, lanes at or above row_count are zero
    typedef struct packed {
        count_t     row_count;
        acc_lanes_t sums;
    } row_result_t;

endpackage

`default_nettype wire

// ==== verilog/product_stage.sv ====
// lane multiply stage
`default_nettype none

`include "spmv_params.svh"

module product_stage (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                in_valid,
    input  wire spmv_pkg::spmv_beat_t in_beat,
    output logic                     prod_valid,
    output spmv_pkg::prod_beat_t     prod
);

    spmv_pkg::prod_beat_t prod_d;

    // four signed 8 x 8 products, control fields ride along
    always_comb begin
        prod_d = '0;
        for (int i = 0; i < `SPMV_LANES; i++) begin
            prod_d.prod[i] = $signed(in_beat.mat[i]) * $signed(in_beat.vec[i]);
        end
        prod_d.bounds = in_beat.bounds;
        prod_d.cont   = in_beat.cont;
    end

    // payload loads every edge, valid follows in_valid
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            prod_valid <= 1'b0;
            prod       <= '0;
        end else begin
            prod_valid <= in_valid;
            prod       <= prod_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/segment_reduce.sv ====
// mask driven segment summation
`default_nettype none

`include "spmv_params.svh"

module segment_reduce (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                prod_valid,
    input  wire spmv_pkg::prod_beat_t prod,
    output logic                     seg_valid,
    output spmv_pkg::seg_beat_t      seg
);

    // product widened to segment width
    function automatic logic [`SPMV_SEG_W-1:0] sext_prod(
        input logic [`SPMV_PROD_W-1:0] p
    );
        sext_prod = {{(`SPMV_SEG_W - `SPMV_PROD_W){p[`SPMV_PROD_W-1]}}, p};
    endfunction

    // bit i set means a segment ends after product i
    logic [`SPMV_LANES-1:0] seg_end;

    // running sum of the open segment
    logic [`SPMV_SEG_W-1:0] run_sum;

    // next free output lane, ends up as the segment count
    spmv_pkg::count_t seg_idx;

    spmv_pkg::seg_beat_t seg_d;

    // the last product always closes a segment
    assign seg_end = {1'b1, prod.bounds};

    // walk left to right, emit a sum at each boundary
    always_comb begin
        run_sum = '0;
        seg_idx = '0;
        seg_d   = '0;
        for (int i = 0; i < `SPMV_LANES; i++) begin
            run_sum = run_sum + sext_prod(prod.prod[i]);
            if (seg_end[i]) begin
                seg_d.sums[seg_idx] = run_sum;
                seg_idx             = seg_idx + 1'b1;
                run_sum             = '0;
            end
        end
        // one per set mask bit, plus the closing lane
        seg_d.seg_count = seg_idx;
        seg_d.cont      = prod.cont;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            seg_valid <= 1'b0;
            seg       <= '0;
        end else begin
            seg_valid <= prod_valid;
            seg       <= seg_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/row_accumulator.sv ====
// cross-beat row accumulator
`default_nettype none

`include "spmv_params.svh"

module row_accumulator (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               seg_valid,
    input  wire spmv_pkg::seg_beat_t seg,
    output logic                    out_valid,
    output spmv_pkg::row_result_t   out_rows
);

    // segment sum widened to row width
    function automatic logic [`SPMV_ACC_W-1:0] sext_seg(
        input logic [`SPMV_SEG_W-1:0] s
    );
        sext_seg = {{(`SPMV_ACC_W - `SPMV_SEG_W){s[`SPMV_SEG_W-1]}}, s};
    endfunction

    // open row from an earlier beat
    logic [`SPMV_ACC_W-1:0] carry;
    logic                   carry_pend;

    spmv_pkg::acc_lanes_t   row_sums;
    spmv_pkg::count_t       last_idx;
    spmv_pkg::count_t       rows_done;
    logic [`SPMV_ACC_W-1:0] carry_d;
    spmv_pkg::row_result_t  result_d;

    always_comb begin
        for (int i = 0; i < `SPMV_LANES; i++) begin
            row_sums[i] = sext_seg(seg.sums[i]);
        end
        // pending carry joins the first segment
        if (carry_pend) begin
            row_sums[0] = row_sums[0] + carry;
        end

        last_idx = seg.seg_count - 1'b1;

        // last segment stays open when cont is set
        carry_d = '0;
        for (int i = 0; i < `SPMV_LANES; i++) begin
            if (`SPMV_CNT_W'(i) == last_idx) begin
                carry_d = row_sums[i];
            end
        end
        rows_done = seg.cont ? last_idx : seg.seg_count;

        // zero every lane past the completed rows
        result_d           = '0;
        result_d.row_count = rows_done;
        for (int i = 0; i < `SPMV_LANES; i++) begin
            if (`SPMV_CNT_W'(i) < rows_done) begin
                result_d.sums[i] = row_sums[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid  <= 1'b0;
            out_rows   <= '0;
            carry      <= '0;
            carry_pend <= 1'b0;
        end else begin
            out_valid <= seg_valid;
            out_rows  <= seg_valid ? result_d : '0;
            // idle cycles keep an open row
            if (seg_valid) begin
                carry      <= seg.cont ? carry_d : '0;
                carry_pend <= seg.cont;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/spmv_alu_top.sv ====
// sparse-row dot product top
`default_nettype none

module spmv_alu_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                in_valid,
    input  wire spmv_pkg::spmv_beat_t in_beat,
    output logic                     out_valid,
    output spmv_pkg::row_result_t    out_rows
);

    // stage 1 to stage 2
    logic                 prod_valid;
    spmv_pkg::prod_beat_t prod_beat;

    // stage 2 to stage 3
    logic                 seg_valid;
    spmv_pkg::seg_beat_t  seg_beat;

    // multiply the four lanes
    product_stage product_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .prod_valid (prod_valid),
        .prod       (prod_beat)
    );

    // fold products into segments
    segment_reduce segment_reduce_inst (
        .clk        (clk),
        .rst        (rst),
        .prod_valid (prod_valid),
        .prod       (prod_beat),
        .seg_valid  (seg_valid),
        .seg        (seg_beat)
    );

    // join rows across beats, three cycles in total
    row_accumulator row_accumulator_inst (
        .clk       (clk),
        .rst       (rst),
        .seg_valid (seg_valid),
        .seg       (seg_beat),
        .out_valid (out_valid),
        .out_rows  (out_rows)
    );

endmodule

`default_nettype wire

// ==== bench/spmv_alu_chk.sv ====
// output assertions for the dot product top
`default_nettype none

`include "spmv_params.svh"

module spmv_alu_chk (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic                  out_valid,
    input wire spmv_pkg::row_result_t out_rows
);

    // no result while reset is held
    reset_quiet: assert property (@(posedge clk) !rst |-> !out_valid)
        else $error("out_valid high during reset");

    // at most one row per lane
    count_range: assert property (@(posedge clk) disable iff (!rst)
        out_rows.row_count <= `SPMV_CNT_W'(`SPMV_LANES))
        else $error("row_count above the lane count");

    // lanes past the completed rows stay zero
    for (genvar i = 0; i < `SPMV_LANES; i++) begin : g_lane
        lane_zero: assert property (@(posedge clk) disable iff (!rst)
            (out_valid && out_rows.row_count <= `SPMV_CNT_W'(i)) |-> out_rows.sums[i] == '0)
            else $error("row sum lane %0d nonzero above row_count", i);
    end

endmodule

bind spmv_alu_top spmv_alu_chk spmv_alu_chk_inst (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .out_rows  (out_rows)
);

`default_nettype wire

// ==== bench/spmv_alu_tb.sv ====
// sparse-row dot product testbench
`default_nettype none

`include "spmv_params.svh"

module spmv_alu_tb;

    localparam int CLK_HALF     = 20;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 5;

    // beats per test phase
    localparam int N_FULL  = 8;
    localparam int N_BOUND = 8;
    localparam int N_RAND  = 60;
    localparam int N_CHAIN = 80;
    localparam int N_WRAP  = 260;
    localparam int TOTAL_BEATS = (N_FULL + 2) + (N_BOUND + 1) + N_RAND
                               + (N_CHAIN + 3) + (N_WRAP + 1);

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    spmv_pkg::spmv_beat_t  in_beat;
    logic                  out_valid;
    spmv_pkg::row_result_t out_rows;

    logic [31:0] lfsr;
    int          cycle = 0;

    // expected results and the cycle each one is due
    spmv_pkg::row_result_t exp_q[$];
    int                    due_q[$];

    // open row as the model sees it
    logic [`SPMV_ACC_W-1:0] model_carry;
    logic                   model_pend;

    spmv_alu_top spmv_alu_top_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_rows  (out_rows)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic spmv_pkg::spmv_beat_t make_beat(input spmv_pkg::elem_lanes_t mat,
                                                       input spmv_pkg::elem_lanes_t vec,
                                                       input spmv_pkg::bounds_t bounds,
                                                       input logic cont);
        spmv_pkg::spmv_beat_t b;
        b.mat    = mat;
        b.vec    = vec;
        b.bounds = bounds;
        b.cont   = cont;
        return b;
    endfunction

    function automatic spmv_pkg::spmv_beat_t random_beat(input spmv_pkg::bounds_t bounds,
                                                         input logic cont);
        spmv_pkg::spmv_beat_t b;
        b = '0;
        for (int i = 0; i < `SPMV_LANES; i++) begin
            b.mat[i] = `SPMV_ELEM_W'(rand_bits(`SPMV_ELEM_W));
            b.vec[i] = `SPMV_ELEM_W'(rand_bits(`SPMV_ELEM_W));
        end
        b.bounds = bounds;
        b.cont   = cont;
        return b;
    endfunction

    // segment, carry and wrap rules applied to one beat
    task automatic predict_beat(input spmv_pkg::spmv_beat_t b,
                                output spmv_pkg::row_result_t r);
        logic signed [`SPMV_PROD_W-1:0] p;
        logic [`SPMV_ACC_W-1:0]         segs [`SPMV_LANES];
        logic [`SPMV_ACC_W-1:0]         acc;
        logic [`SPMV_LANES-1:0]         ends;
        int                             n;
        int                             rows;
        r    = '0;
        acc  = '0;
        n    = 0;
        // product 3 always ends the last segment
        ends = {1'b1, b.bounds};
        for (int i = 0; i < `SPMV_LANES; i++) begin
            segs[i] = '0;
        end
        for (int i = 0; i < `SPMV_LANES; i++) begin
            p   = $signed(b.mat[i]) * $signed(b.vec[i]);
            acc = acc + {{(`SPMV_ACC_W - `SPMV_PROD_W){p[`SPMV_PROD_W-1]}}, p};
            if (ends[i]) begin
                segs[n] = acc;
                n       = n + 1;
                acc     = '0;
            end
        end
        if (model_pend) begin
            segs[0] = segs[0] + model_carry;
        end
        if (b.cont) begin
            rows        = n - 1;
            model_carry = segs[n-1];
            model_pend  = 1'b1;
        end else begin
            rows        = n;
            model_carry = '0;
            model_pend  = 1'b0;
        end
        r.row_count = spmv_pkg::count_t'(rows);
        for (int i = 0; i < rows; i++) begin
            r.sums[i] = segs[i];
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error %s: expected %h, got %h at cycle %0d", name, exp, act, cycle);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp) begin
            report_mismatch("out_valid", 32'(exp), 32'(act));
        end
    endtask

    task automatic check_rows(input spmv_pkg::row_result_t exp,
                              input spmv_pkg::row_result_t act);
        if (act.row_count !== exp.row_count) begin
            report_mismatch("out_rows.row_count", 32'(exp.row_count), 32'(act.row_count));
        end
        for (int i = 0; i < `SPMV_LANES; i++) begin
            if (act.sums[i] !== exp.sums[i]) begin
                report_mismatch($sformatf("out_rows.sums[%0d]", i),
                                32'(exp.sums[i]), 32'(act.sums[i]));
            end
        end
    endtask

    task automatic send_beat(input spmv_pkg::spmv_beat_t b);
        spmv_pkg::row_result_t r;
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b1;
        in_beat  = b;
        predict_beat(b, r);
        exp_q.push_back(r);
        // sampled on the next edge, out after two more
        due_q.push_back(cycle + 3);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
            in_valid = 1'b0;
            // junk payload, must not touch the carry
            in_beat  = random_beat(spmv_pkg::bounds_t'(rand_bits(3)), 1'(rand_bits(1)));
        end
    endtask

    // roughly one beat in four gets an idle cycle first
    task automatic random_gap();
        if (rand_bits(2) == 32'd0) begin
            idle_cycles(1);
        end
    endtask

    task automatic run_full_rows();
        send_beat(make_beat(32'h8080_8080, 32'h8080_8080, 3'b000, 1'b0));
        send_beat(make_beat(32'h7f7f_7f7f, 32'h8080_8080, 3'b000, 1'b0));
        repeat (N_FULL) send_beat(random_beat(3'b000, 1'b0));
    endtask

    task automatic run_all_bounds();
        // products 16384, -16256, -16256, -1
        send_beat(make_beat(32'h0180_7f80, 32'hff7f_8080, 3'b111, 1'b0));
        repeat (N_BOUND) send_beat(random_beat(3'b111, 1'b0));
    endtask

    task automatic run_random_masks();
        repeat (N_RAND) begin
            random_gap();
            send_beat(random_beat(spmv_pkg::bounds_t'(rand_bits(3)), 1'b0));
        end
    endtask

    task automatic run_chains();
        spmv_pkg::bounds_t bounds;
        // open row held across an idle stretch
        send_beat(random_beat(3'b000, 1'b1));
        idle_cycles(4);
        send_beat(random_beat(3'b000, 1'b1));
        send_beat(random_beat(spmv_pkg::bounds_t'(rand_bits(3)), 1'b0));
        repeat (N_CHAIN) begin
            random_gap();
            // fully open beats now and then
            bounds = (rand_bits(2) == 32'd0) ? '0 : spmv_pkg::bounds_t'(rand_bits(3));
            send_beat(random_beat(bounds, 1'(rand_bits(1))));
        end
    endtask

    // long open row, the sum passes 2^24
    task automatic run_wrap();
        repeat (N_WRAP) send_beat(make_beat(32'h8080_8080, 32'h8080_8080, 3'b000, 1'b1));
        send_beat(make_beat(32'h8080_8080, 32'h8080_8080, 3'b000, 1'b0));
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        logic expect_valid;
        expect_valid = 1'b0;
        if (due_q.size() != 0) begin
            expect_valid = (due_q[0] == cycle);
        end
        check_valid(expect_valid, out_valid);
        if (expect_valid) begin
            check_rows(exp_q[0], out_rows);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end else begin
            check_rows('0, out_rows);
        end
    end

    initial begin
        #((TOTAL_BEATS + 20) * 2 * CLK_PERIOD);
        $display("watchdog expired before all results arrived");
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        rst         = 1'b0;
        in_valid    = 1'b0;
        in_beat     = '0;
        lfsr        = 32'd96680;
        model_carry = '0;
        model_pend  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;
        idle_cycles(3);
        run_full_rows();
        run_all_bounds();
        run_random_masks();
        run_chains();
        run_wrap();
        idle_cycles(1);
        while (due_q.size() != 0) begin
            @(posedge clk);
        end
        idle_cycles(4);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
verilog/spmv_pkg.sv
verilog/product_stage.sv
verilog/segment_reduce.sv
verilog/row_accumulator.sv
verilog/spmv_alu_top.sv
bench/spmv_alu_chk.sv
bench/spmv_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build the testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --top-module spmv_alu_tb -f project.f -o spmv_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/spmv_sim 2>&1 | tee sim.log
run_status=$?
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
[ "$run_status" -eq 0 ] && echo "PASS" || { echo "simulation stopped abnormally"; exit 1; }
